// File: verilog/ooo_pkg.sv
// Shared sizes, opcodes and packets of the out-of-order integer core
// ROB-based renaming with one pipelined ALU on the CDB
package ooo_pkg;

    ////////////////////
    // Sizes
    ////////////////////
    localparam int XLEN          = 32;
    localparam int NUM_ARCH_REGS = 32;
    localparam int REG_IDX_W     = $clog2(NUM_ARCH_REGS);
    localparam int ROB_DEPTH     = 8;
    localparam int ROB_TAG_W     = $clog2(ROB_DEPTH);
    localparam int RS_DEPTH      = 4;
    localparam int IMM_W         = 12;

    // r0 reads as zero, never renamed or written
    localparam logic [REG_IDX_W-1:0] ZERO_REG = '0;

    ////////////////////
    // Opcodes
    ////////////////////
    typedef enum logic [2:0] {
        ADD  = 3'd0,
        SUB  = 3'd1,
        AND  = 3'd2,
        OR   = 3'd3,
        XOR  = 3'd4,
        ADDI = 3'd5
    } alu_op_e;

    ////////////////////
    // Packets
    ////////////////////
    // Decoded instruction at the core input
    typedef struct packed {
        alu_op_e                 op;
        logic [REG_IDX_W-1:0]    dest;
        logic [REG_IDX_W-1:0]    src1;
        logic [REG_IDX_W-1:0]    src2;
        logic signed [IMM_W-1:0] imm;
    } inst_t;

    // Source operand, value valid only when ready
    typedef struct packed {
        logic                 ready;
        logic [ROB_TAG_W-1:0] tag;
        logic [XLEN-1:0]      value;
    } operand_t;

    // Renamed instruction, valid is the dispatch fire
    typedef struct packed {
        logic                    valid;
        alu_op_e                 op;
        logic                    has_dest;
        logic [REG_IDX_W-1:0]    dest;
        logic [ROB_TAG_W-1:0]    rob_tag;
        operand_t                opa;
        operand_t                opb;
        logic signed [IMM_W-1:0] imm;
    } dp_packet_t;

    // RS to ALU
    typedef struct packed {
        logic                    valid;
        alu_op_e                 op;
        logic [ROB_TAG_W-1:0]    rob_tag;
        logic [XLEN-1:0]         opa;
        logic [XLEN-1:0]         opb;
        logic signed [IMM_W-1:0] imm;
    } issue_packet_t;

    // Result broadcast
    typedef struct packed {
        logic                 valid;
        logic [ROB_TAG_W-1:0] tag;
        logic [XLEN-1:0]      value;
    } cdb_t;

    // Head entry leaving the ROB
    typedef struct packed {
        logic                 valid;
        logic                 has_dest;
        logic [REG_IDX_W-1:0] dest;
        logic [ROB_TAG_W-1:0] tag;
        logic [XLEN-1:0]      value;
    } retire_t;

endpackage

// File: verilog/alu_fu.sv
// Single-cycle pipelined ALU
// Result register doubles as the CDB broadcast
`timescale 1ns/1ps

module alu_fu (
    input  logic                    clock,
    input  logic                    rst,
    input  ooo_pkg::issue_packet_t  issue,
    output ooo_pkg::cdb_t           cdb
);

    logic [ooo_pkg::XLEN-1:0] imm_ext;
    logic [ooo_pkg::XLEN-1:0] result;

    // Sign-extend the 12-bit immediate
    assign imm_ext = {{(ooo_pkg::XLEN - ooo_pkg::IMM_W){issue.imm[ooo_pkg::IMM_W-1]}}, issue.imm};

    always_comb begin
        case (issue.op)
            ooo_pkg::ADD:  result = issue.opa + issue.opb;
            ooo_pkg::SUB:  result = issue.opa - issue.opb;
            ooo_pkg::AND:  result = issue.opa & issue.opb;
            ooo_pkg::OR:   result = issue.opa | issue.opb;
            ooo_pkg::XOR:  result = issue.opa ^ issue.opb;
            ooo_pkg::ADDI: result = issue.opa + imm_ext;
            default:       result = '0;
        endcase
    end

    // One result per cycle, valid for a single cycle
    always_ff @(posedge clock) begin
        if (rst) begin
            cdb.valid <= 1'b0;
        end else begin
            cdb.valid <= issue.valid;
        end
        cdb.tag   <= issue.rob_tag;
        cdb.value <= result;
    end

endmodule

// File: verilog/rs.sv
// Reservation stations for the ALU
// Holds renamed instructions until both operands arrive, then issues
`timescale 1ns/1ps

module rs (
    input  logic                    clock,
    input  logic                    rst,
    input  ooo_pkg::dp_packet_t     dp_packet,
    input  ooo_pkg::cdb_t           cdb,
    output logic                    rs_full,
    output ooo_pkg::issue_packet_t  issue
);

    localparam int RS_IDX_W = $clog2(ooo_pkg::RS_DEPTH);

    // Entry valid bit marks an occupied station
    ooo_pkg::dp_packet_t ent [ooo_pkg::RS_DEPTH];

    logic                free_found;
    logic [RS_IDX_W-1:0] free_idx;
    logic                iss_found;
    logic [RS_IDX_W-1:0] iss_idx;

    ////////////////////
    // Slot selection
    ////////////////////
    always_comb begin
        free_found = 1'b0;
        free_idx   = '0;
        iss_found  = 1'b0;
        iss_idx    = '0;
        // Lowest index wins in both searches
        for (int i = 0; i < ooo_pkg::RS_DEPTH; i++) begin
            if (!ent[i].valid && !free_found) begin
                free_found = 1'b1;
                free_idx   = RS_IDX_W'(i);
            end
            if (ent[i].valid && ent[i].opa.ready && ent[i].opb.ready && !iss_found) begin
                iss_found = 1'b1;
                iss_idx   = RS_IDX_W'(i);
            end
        end
    end

    assign rs_full = !free_found;

    always_comb begin
        issue.valid   = iss_found;
        issue.op      = ent[iss_idx].op;
        issue.rob_tag = ent[iss_idx].rob_tag;
        issue.opa     = ent[iss_idx].opa.value;
        issue.opb     = ent[iss_idx].opb.value;
        issue.imm     = ent[iss_idx].imm;
    end

    ////////////////////
    // Entry update
    ////////////////////
    always_ff @(posedge clock) begin
        if (rst) begin
            for (int i = 0; i < ooo_pkg::RS_DEPTH; i++) begin
                ent[i].valid <= 1'b0;
            end
        end else begin
            // Wake waiting operands on a tag match
            for (int i = 0; i < ooo_pkg::RS_DEPTH; i++) begin
                if (cdb.valid && ent[i].valid) begin
                    if (!ent[i].opa.ready && ent[i].opa.tag == cdb.tag) begin
                        ent[i].opa.ready <= 1'b1;
                        ent[i].opa.value <= cdb.value;
                    end
                    if (!ent[i].opb.ready && ent[i].opb.tag == cdb.tag) begin
                        ent[i].opb.ready <= 1'b1;
                        ent[i].opb.value <= cdb.value;
                    end
                end
            end
            // Issued entry frees at this edge
            if (iss_found) begin
                ent[iss_idx].valid <= 1'b0;
            end
            // New packet lands in a slot that was free this cycle
            if (dp_packet.valid) begin
                ent[free_idx] <= dp_packet;
            end
        end
    end

endmodule

// File: verilog/rob.sv
// Reorder buffer
// Allocates tags at the tail, records CDB results, retires the head in order
`timescale 1ns/1ps

module rob (
    input  logic                           clock,
    input  logic                           rst,
    input  ooo_pkg::dp_packet_t            dp_packet,
    input  ooo_pkg::cdb_t                  cdb,
    input  logic [ooo_pkg::ROB_TAG_W-1:0]  query_tag1,
    input  logic [ooo_pkg::ROB_TAG_W-1:0]  query_tag2,
    output logic [ooo_pkg::ROB_TAG_W-1:0]  rob_tail,
    output logic                           rob_full,
    output logic                           rob_done1,
    output logic [ooo_pkg::XLEN-1:0]       rob_val1,
    output logic                           rob_done2,
    output logic [ooo_pkg::XLEN-1:0]       rob_val2,
    output ooo_pkg::retire_t               retire
);

    localparam int CNT_W = ooo_pkg::ROB_TAG_W + 1;

    logic [ooo_pkg::ROB_TAG_W-1:0] head;
    logic [ooo_pkg::ROB_TAG_W-1:0] tail;
    logic [CNT_W-1:0]              count;

    // Entry fields
    logic [ooo_pkg::REG_IDX_W-1:0] ent_dest     [ooo_pkg::ROB_DEPTH];
    logic                          ent_has_dest [ooo_pkg::ROB_DEPTH];
    logic                          ent_done     [ooo_pkg::ROB_DEPTH];
    logic [ooo_pkg::XLEN-1:0]      ent_value    [ooo_pkg::ROB_DEPTH];

    logic alloc;
    logic pop;

    assign alloc    = dp_packet.valid;
    assign rob_tail = tail;
    assign rob_full = (count == CNT_W'(ooo_pkg::ROB_DEPTH));

    ////////////////////
    // Operand lookups
    ////////////////////
    assign rob_done1 = ent_done[query_tag1];
    assign rob_val1  = ent_value[query_tag1];
    assign rob_done2 = ent_done[query_tag2];
    assign rob_val2  = ent_value[query_tag2];

    ////////////////////
    // Retire
    ////////////////////
    // Head leaves one cycle after its CDB pulse
    assign pop = (count != '0) && ent_done[head];

    always_comb begin
        retire.valid    = pop;
        retire.has_dest = pop && ent_has_dest[head];
        retire.dest     = ent_dest[head];
        retire.tag      = head;
        retire.value    = ent_value[head];
    end

    // Pointers, occupancy and completion flags
    always_ff @(posedge clock) begin
        if (rst) begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
            for (int i = 0; i < ooo_pkg::ROB_DEPTH; i++) begin
                ent_done[i] <= 1'b0;
            end
        end else begin
            if (alloc) begin
                tail           <= tail + 1'b1;
                ent_done[tail] <= 1'b0;
            end
            if (pop) begin
                head <= head + 1'b1;
            end
            count <= count + CNT_W'(alloc) - CNT_W'(pop);
            if (cdb.valid) begin
                ent_done[cdb.tag] <= 1'b1;
            end
        end
    end

    // Entry payload
    always_ff @(posedge clock) begin
        if (alloc) begin
            ent_dest[tail]     <= dp_packet.dest;
            ent_has_dest[tail] <= dp_packet.has_dest;
        end
        if (cdb.valid) begin
            ent_value[cdb.tag] <= cdb.value;
        end
    end

endmodule

// File: verilog/map_table.sv
// Rename map table
// Tracks which ROB tag will produce each architectural register
`timescale 1ns/1ps

module map_table (
    input  logic                           clock,
    input  logic                           rst,
    input  logic [ooo_pkg::REG_IDX_W-1:0]  src1,
    input  logic [ooo_pkg::REG_IDX_W-1:0]  src2,
    input  ooo_pkg::dp_packet_t            dp_packet,
    input  ooo_pkg::retire_t               retire,
    output logic                           map_busy1,
    output logic [ooo_pkg::ROB_TAG_W-1:0]  map_tag1,
    output logic                           map_busy2,
    output logic [ooo_pkg::ROB_TAG_W-1:0]  map_tag2
);

    logic                          busy [ooo_pkg::NUM_ARCH_REGS];
    logic [ooo_pkg::ROB_TAG_W-1:0] tags [ooo_pkg::NUM_ARCH_REGS];

    // Retiring producer still owns the mapping
    function automatic logic retiring(input logic [ooo_pkg::REG_IDX_W-1:0] idx);
        return retire.valid && retire.has_dest && retire.dest == idx
               && retire.tag == tags[idx];
    endfunction

    // Busy drops early for a register retiring now
    assign map_busy1 = busy[src1] && !retiring(src1);
    assign map_busy2 = busy[src2] && !retiring(src2);
    assign map_tag1  = tags[src1];
    assign map_tag2  = tags[src2];

    always_ff @(posedge clock) begin
        if (rst) begin
            for (int i = 0; i < ooo_pkg::NUM_ARCH_REGS; i++) begin
                busy[i] <= 1'b0;
            end
        end else begin
            if (retiring(retire.dest)) begin
                busy[retire.dest] <= 1'b0;
            end
            // Dispatch comes last so it wins on the same register
            if (dp_packet.valid && dp_packet.has_dest) begin
                busy[dp_packet.dest] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (dp_packet.valid && dp_packet.has_dest) begin
            tags[dp_packet.dest] <= dp_packet.rob_tag;
        end
    end

endmodule

// File: verilog/dispatch_stage.sv
// Dispatch stage with the architectural register file
// Accepts one instruction per cycle and resolves its source operands
`timescale 1ns/1ps

module dispatch_stage (
    input  logic                           clock,
    input  logic                           rst,
    input  logic                           inst_valid,
    input  ooo_pkg::inst_t                 inst,
    input  logic                           rob_full,
    input  logic                           rs_full,
    input  logic [ooo_pkg::ROB_TAG_W-1:0]  rob_tail,
    input  logic                           map_busy1,
    input  logic [ooo_pkg::ROB_TAG_W-1:0]  map_tag1,
    input  logic                           map_busy2,
    input  logic [ooo_pkg::ROB_TAG_W-1:0]  map_tag2,
    input  logic                           rob_done1,
    input  logic [ooo_pkg::XLEN-1:0]       rob_val1,
    input  logic                           rob_done2,
    input  logic [ooo_pkg::XLEN-1:0]       rob_val2,
    input  ooo_pkg::cdb_t                  cdb,
    input  ooo_pkg::retire_t               retire,
    output logic                           inst_ready,
    output ooo_pkg::dp_packet_t            dp_packet
);

    logic [ooo_pkg::XLEN-1:0] regs [ooo_pkg::NUM_ARCH_REGS];
    logic                     fire;

    // Operand source priority: r0, regfile, ROB, CDB, else wait on tag
    function automatic ooo_pkg::operand_t resolve(
        input logic [ooo_pkg::REG_IDX_W-1:0] src,
        input logic                          busy,
        input logic [ooo_pkg::ROB_TAG_W-1:0] tag,
        input logic                          done,
        input logic [ooo_pkg::XLEN-1:0]      rob_val
    );
        ooo_pkg::operand_t opnd;
        opnd.tag   = tag;
        opnd.ready = 1'b1;
        if (src == ooo_pkg::ZERO_REG) begin
            opnd.value = '0;
        end else if (!busy) begin
            // Retiring writer is forwarded ahead of the regfile
            if (retire.valid && retire.has_dest && retire.dest == src) begin
                opnd.value = retire.value;
            end else begin
                opnd.value = regs[src];
            end
        end else if (done) begin
            opnd.value = rob_val;
        end else if (cdb.valid && cdb.tag == tag) begin
            opnd.value = cdb.value;
        end else begin
            opnd.ready = 1'b0;
            opnd.value = '0;
        end
        return opnd;
    endfunction

    ////////////////////
    // Accept
    ////////////////////
    assign inst_ready = !rob_full && !rs_full;
    assign fire       = inst_valid && inst_ready;

    always_comb begin
        dp_packet.valid    = fire;
        dp_packet.op       = inst.op;
        dp_packet.has_dest = (inst.dest != ooo_pkg::ZERO_REG);
        dp_packet.dest     = inst.dest;
        dp_packet.rob_tag  = rob_tail;
        dp_packet.imm      = inst.imm;
        dp_packet.opa      = resolve(inst.src1, map_busy1, map_tag1, rob_done1, rob_val1);
        dp_packet.opb      = resolve(inst.src2, map_busy2, map_tag2, rob_done2, rob_val2);
        // ADDI takes imm, so src2 never blocks it
        if (inst.op == ooo_pkg::ADDI) begin
            dp_packet.opb.ready = 1'b1;
        end
    end

    ////////////////////
    // Register file
    ////////////////////
    always_ff @(posedge clock) begin
        if (rst) begin
            for (int i = 0; i < ooo_pkg::NUM_ARCH_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (retire.valid && retire.has_dest) begin
            regs[retire.dest] <= retire.value;
        end
    end

endmodule

// File: verilog/ooo_core.sv
// Out-of-order integer core top level
// Dispatch, rename map, reorder buffer, reservation stations and ALU
`timescale 1ns/1ps

module ooo_core (
    input  logic                               clock,
    input  logic                               rst,
    input  logic                               inst_valid,
    input  ooo_pkg::inst_t                     inst,
    output logic                               inst_ready,
    output logic                               commit_valid,
    output logic                               commit_wr_en,
    output logic [ooo_pkg::REG_IDX_W-1:0]      commit_wr_idx,
    output logic [ooo_pkg::XLEN-1:0]           commit_wr_data
);

    ////////////////////
    // Core wires
    ////////////////////
    ooo_pkg::dp_packet_t                dp_packet;
    ooo_pkg::issue_packet_t             issue;
    ooo_pkg::cdb_t                      cdb;
    ooo_pkg::retire_t                   retire;

    // Map table answers
    logic                               map_busy1;
    logic                               map_busy2;
    logic [ooo_pkg::ROB_TAG_W-1:0]      map_tag1;
    logic [ooo_pkg::ROB_TAG_W-1:0]      map_tag2;

    // ROB status and lookups
    logic [ooo_pkg::ROB_TAG_W-1:0]      rob_tail;
    logic                               rob_full;
    logic                               rob_done1;
    logic                               rob_done2;
    logic [ooo_pkg::XLEN-1:0]           rob_val1;
    logic [ooo_pkg::XLEN-1:0]           rob_val2;

    logic                               rs_full;

    ////////////////////
    // Commit outputs
    ////////////////////
    assign commit_valid   = retire.valid;
    assign commit_wr_en   = retire.has_dest;
    assign commit_wr_idx  = retire.dest;
    assign commit_wr_data = retire.value;

    dispatch_stage u_dispatch_stage (
        .clock      (clock),
        .rst        (rst),
        .inst_valid (inst_valid),
        .inst       (inst),
        .rob_full   (rob_full),
        .rs_full    (rs_full),
        .rob_tail   (rob_tail),
        .map_busy1  (map_busy1),
        .map_tag1   (map_tag1),
        .map_busy2  (map_busy2),
        .map_tag2   (map_tag2),
        .rob_done1  (rob_done1),
        .rob_val1   (rob_val1),
        .rob_done2  (rob_done2),
        .rob_val2   (rob_val2),
        .cdb        (cdb),
        .retire     (retire),
        .inst_ready (inst_ready),
        .dp_packet  (dp_packet)
    );

    // Sources looked up straight from the incoming instruction
    map_table u_map_table (
        .clock     (clock),
        .rst       (rst),
        .src1      (inst.src1),
        .src2      (inst.src2),
        .dp_packet (dp_packet),
        .retire    (retire),
        .map_busy1 (map_busy1),
        .map_tag1  (map_tag1),
        .map_busy2 (map_busy2),
        .map_tag2  (map_tag2)
    );

    rob u_rob (
        .clock      (clock),
        .rst        (rst),
        .dp_packet  (dp_packet),
        .cdb        (cdb),
        .query_tag1 (map_tag1),
        .query_tag2 (map_tag2),
        .rob_tail   (rob_tail),
        .rob_full   (rob_full),
        .rob_done1  (rob_done1),
        .rob_val1   (rob_val1),
        .rob_done2  (rob_done2),
        .rob_val2   (rob_val2),
        .retire     (retire)
    );

    rs u_rs (
        .clock     (clock),
        .rst       (rst),
        .dp_packet (dp_packet),
        .cdb       (cdb),
        .rs_full   (rs_full),
        .issue     (issue)
    );

    // Single FU, its output register is the CDB
    alu_fu u_alu_fu (
        .clock (clock),
        .rst   (rst),
        .issue (issue),
        .cdb   (cdb)
    );

endmodule

// File: tb/ooo_ref_model.svh
// Reference model of the out-of-order core
// Executes each accepted instruction in program order and predicts its commit
`ifndef OOO_REF_MODEL_SVH
`define OOO_REF_MODEL_SVH

// Expected commit fields
typedef struct packed {
    logic                          wr_en;
    logic [ooo_pkg::REG_IDX_W-1:0] idx;
    logic [ooo_pkg::XLEN-1:0]      data;
} commit_exp_t;

// Model architectural state
logic [ooo_pkg::XLEN-1:0] model_regs [ooo_pkg::NUM_ARCH_REGS];

function automatic void clear_model();
    for (int i = 0; i < ooo_pkg::NUM_ARCH_REGS; i++) begin
        model_regs[i] = '0;
    end
endfunction

function automatic commit_exp_t predict_commit(input ooo_pkg::inst_t ins);
    commit_exp_t                     pred;
    logic [ooo_pkg::XLEN-1:0]        a;
    logic [ooo_pkg::XLEN-1:0]        b;
    logic signed [ooo_pkg::XLEN-1:0] imm_ext;
    // r0 always reads as zero
    a = (ins.src1 == 0) ? '0 : model_regs[ins.src1];
    b = (ins.src2 == 0) ? '0 : model_regs[ins.src2];
    // Signed source widens with its sign bit
    imm_ext = ins.imm;
    case (ins.op)
        ooo_pkg::ADD:  pred.data = a + b;
        ooo_pkg::SUB:  pred.data = a - b;
        ooo_pkg::AND:  pred.data = a & b;
        ooo_pkg::OR:   pred.data = a | b;
        ooo_pkg::XOR:  pred.data = a ^ b;
        ooo_pkg::ADDI: pred.data = a + imm_ext;
        default:       pred.data = '0;
    endcase
    pred.wr_en = (ins.dest != 0);
    pred.idx   = ins.dest;
    if (pred.wr_en) begin
        model_regs[ins.dest] = pred.data;
    end
    return pred;
endfunction

`endif

// File: tb/ooo_core_tb.sv
// Testbench for the out-of-order core
// Directed and random instruction streams checked against an in-order model
`timescale 1ns/1ps

module ooo_core_tb;

    localparam int CLK_PERIOD   = 4;
    localparam int DRIVE_DELAY  = 1;
    localparam int NUM_DIRECTED = 36;
    localparam int NUM_CHAIN    = 24;
    localparam int NUM_RAND     = 60;
    localparam int TOTAL_INSTS  = NUM_DIRECTED + NUM_CHAIN + NUM_RAND;
    localparam int WATCHDOG_NS  = TOTAL_INSTS * 20 * CLK_PERIOD;

    logic                          clock;
    logic                          rst;
    logic                          inst_valid;
    ooo_pkg::inst_t                inst;
    logic                          inst_ready;
    logic                          commit_valid;
    logic                          commit_wr_en;
    logic [ooo_pkg::REG_IDX_W-1:0] commit_wr_idx;
    logic [ooo_pkg::XLEN-1:0]      commit_wr_data;

    `include "ooo_ref_model.svh"

    // Scoreboard state
    commit_exp_t exp_q [$];
    int          accept_cnt;
    int          commit_cnt;
    int          errors;
    int          tests_run;
    int          tests_failed;
    int          test_err0;
    int          test_acc0;
    int          test_com0;
    string       cur_test;
    logic        saw_stall;
    integer      seed;

    ooo_core u_dut (
        .clock          (clock),
        .rst            (rst),
        .inst_valid     (inst_valid),
        .inst           (inst),
        .inst_ready     (inst_ready),
        .commit_valid   (commit_valid),
        .commit_wr_en   (commit_wr_en),
        .commit_wr_idx  (commit_wr_idx),
        .commit_wr_data (commit_wr_data)
    );

    initial begin
        clock = 1'b0;
        forever #(CLK_PERIOD / 2) clock = ~clock;
    end

    ////////////////////
    // Accept and commit monitor
    ////////////////////
    // Sampled at negedge when all outputs have settled
    always @(negedge clock) begin
        commit_exp_t pred;
        if (!rst) begin
            // Pop before push so a same-cycle accept stays queued
            if (commit_valid) begin
                commit_cnt++;
                if (exp_q.size() == 0) begin
                    $display("%s: commit seen with no instruction outstanding", cur_test);
                    errors++;
                end else begin
                    pred = exp_q.pop_front();
                    assert (commit_wr_en === pred.wr_en) else begin
                        $display("[FAIL] %s: commit_wr_en expected %0b actual %0b",
                                 cur_test, pred.wr_en, commit_wr_en);
                        errors++;
                    end
                    assert (commit_wr_idx === pred.idx) else begin
                        $display("[FAIL] %s: commit_wr_idx expected %0d actual %0d",
                                 cur_test, pred.idx, commit_wr_idx);
                        errors++;
                    end
                    assert (commit_wr_data === pred.data) else begin
                        $display("[FAIL] %s: commit_wr_data expected %h actual %h",
                                 cur_test, pred.data, commit_wr_data);
                        errors++;
                    end
                end
            end
            if (inst_valid && inst_ready) begin
                exp_q.push_back(predict_commit(inst));
                accept_cnt++;
            end
            if (!inst_ready) begin
                saw_stall = 1'b1;
            end
        end
    end

    // Hard stop if commits dry up
    initial begin
        #(WATCHDOG_NS);
        $display("Watchdog expired after %0d ns, the core stopped committing", WATCHDOG_NS);
        $display("Test failed");
        $finish;
    end

    ////////////////////
    // Stimulus helpers
    ////////////////////
    function automatic ooo_pkg::inst_t make_inst(
        input ooo_pkg::alu_op_e op,
        input int               dest,
        input int               src1,
        input int               src2,
        input int               imm
    );
        ooo_pkg::inst_t i;
        i.op   = op;
        i.dest = ooo_pkg::REG_IDX_W'(dest);
        i.src1 = ooo_pkg::REG_IDX_W'(src1);
        i.src2 = ooo_pkg::REG_IDX_W'(src2);
        i.imm  = ooo_pkg::IMM_W'(imm);
        return i;
    endfunction

    // Registers limited to r0..r7 for dense dependencies
    function automatic ooo_pkg::inst_t rand_inst();
        ooo_pkg::inst_t i;
        i.op   = ooo_pkg::alu_op_e'({$random(seed)} % 6);
        i.dest = ooo_pkg::REG_IDX_W'({$random(seed)} % 8);
        i.src1 = ooo_pkg::REG_IDX_W'({$random(seed)} % 8);
        i.src2 = ooo_pkg::REG_IDX_W'({$random(seed)} % 8);
        i.imm  = ooo_pkg::IMM_W'($random(seed));
        return i;
    endfunction

    // Hold valid until the DUT takes it
    task automatic send(input ooo_pkg::inst_t i);
        logic taken;
        taken      = 1'b0;
        inst_valid = 1'b1;
        inst       = i;
        while (!taken) begin
            @(negedge clock);
            taken = inst_ready;
            @(posedge clock);
            #(DRIVE_DELAY);
        end
        inst_valid = 1'b0;
    endtask

    task automatic idle(input int n);
        repeat (n) begin
            @(posedge clock);
            #(DRIVE_DELAY);
        end
    endtask

    task automatic start_test(input string name);
        cur_test  = name;
        test_err0 = errors;
        test_acc0 = accept_cnt;
        test_com0 = commit_cnt;
    endtask

    // Wait for every accepted instruction to commit
    task automatic drain();
        wait (commit_cnt == accept_cnt);
        idle(4);
    endtask

    task automatic report_test();
        tests_run++;
        if (errors != test_err0) begin
            tests_failed++;
        end
        $display("%s: %0d accepted, %0d committed, %0d errors", cur_test,
                 accept_cnt - test_acc0, commit_cnt - test_com0, errors - test_err0);
    endtask

    ////////////////////
    // Test sequence
    ////////////////////
    initial begin
        seed       = 32'h5b00;
        rst        = 1'b1;
        inst_valid = 1'b0;
        inst       = '0;
        accept_cnt = 0;
        commit_cnt = 0;
        errors     = 0;
        tests_run  = 0;
        tests_failed = 0;
        saw_stall  = 1'b0;
        cur_test   = "reset";
        clear_model();
        repeat (5) @(posedge clock);
        #(DRIVE_DELAY);
        rst = 1'b0;

        // Idle state and zeroed register file
        start_test("reset_state");
        assert (inst_ready === 1'b1) else begin
            $display("inst_ready is not high after reset");
            errors++;
        end
        assert (commit_valid === 1'b0) else begin
            $display("commit_valid is not low after reset");
            errors++;
        end
        send(make_inst(ooo_pkg::ADD, 3, 1, 2, 0));
        send(make_inst(ooo_pkg::OR, 4, 5, 6, 0));
        send(make_inst(ooo_pkg::SUB, 7, 7, 0, 0));
        send(make_inst(ooo_pkg::ADDI, 2, 9, 0, 0));
        drain();
        report_test();

        // One of each opcode with negative immediates
        start_test("alu_ops");
        send(make_inst(ooo_pkg::ADDI, 1, 0, 0, 1234));
        send(make_inst(ooo_pkg::ADDI, 2, 0, 0, -300));
        idle(3);
        send(make_inst(ooo_pkg::ADD, 3, 1, 2, 0));
        send(make_inst(ooo_pkg::SUB, 4, 1, 2, 0));
        send(make_inst(ooo_pkg::AND, 5, 1, 2, 0));
        send(make_inst(ooo_pkg::OR, 6, 1, 2, 0));
        send(make_inst(ooo_pkg::XOR, 7, 1, 2, 0));
        send(make_inst(ooo_pkg::ADDI, 8, 1, 0, -2048));
        drain();
        report_test();

        // Varying gaps hit regfile, ROB and CDB operand paths
        start_test("dep_chain");
        for (int k = 0; k < 8; k++) begin
            send(make_inst(ooo_pkg::ADDI, 1, 1, 0, k * 3 + 1));
            send(make_inst(ooo_pkg::ADD, 2, 1, 2, 0));
            idle(k % 4);
        end
        send(make_inst(ooo_pkg::SUB, 3, 2, 1, 0));
        send(make_inst(ooo_pkg::XOR, 1, 3, 2, 0));
        drain();
        report_test();

        start_test("zero_dest");
        send(make_inst(ooo_pkg::ADDI, 0, 0, 0, 55));
        send(make_inst(ooo_pkg::ADD, 0, 1, 2, 0));
        send(make_inst(ooo_pkg::ADD, 5, 0, 0, 0));
        send(make_inst(ooo_pkg::OR, 6, 0, 1, 0));
        send(make_inst(ooo_pkg::ADDI, 0, 6, 0, -1));
        send(make_inst(ooo_pkg::SUB, 7, 0, 6, 0));
        drain();
        report_test();

        // Back-to-back dependent chain to fill RS and ROB
        start_test("backpressure");
        saw_stall = 1'b0;
        for (int k = 0; k < NUM_CHAIN; k++) begin
            send(make_inst(ooo_pkg::ADDI, 1, 1, 0, 1));
        end
        drain();
        assert (saw_stall) else begin
            $display("%s: inst_ready never dropped during the chain", cur_test);
            errors++;
        end
        assert (commit_cnt - test_com0 == accept_cnt - test_acc0) else begin
            $display("[FAIL] %s: commits expected %0d actual %0d", cur_test,
                     accept_cnt - test_acc0, commit_cnt - test_com0);
            errors++;
        end
        report_test();

        start_test("random_mix");
        for (int k = 0; k < NUM_RAND; k++) begin
            send(rand_inst());
            if ({$random(seed)} % 4 == 0) begin
                idle({$random(seed)} % 3 + 1);
            end
        end
        drain();
        report_test();

        assert (exp_q.size() == 0) else begin
            $display("%0d accepted instructions never committed", exp_q.size());
            errors++;
        end
        $display("Summary: %0d tests, %0d failed, %0d accepted, %0d committed, %0d errors",
                 tests_run, tests_failed, accept_cnt, commit_cnt, errors);
        if (errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// File: sim.f
+incdir+tb
verilog/ooo_pkg.sv
verilog/alu_fu.sv
verilog/rs.sv
verilog/rob.sv
verilog/map_table.sv
verilog/dispatch_stage.sv
verilog/ooo_core.sv
tb/ooo_core_tb.sv
